//--- bench/datapathTb.sv
`timescale 1ns/1ns
`default_nettype none

module datapathTb
    import dataPkg::*, isaPkg::*;
();

    logic       clk;
    logic       rstN;
    ctrlStrobes ctrl;
    word        mdataIn;
    word        busWord, pcWord, marAddr, irWord;
    logic       chkBus, chkPc, chkMar, chkIr; // Check enables set with each strobe step.
    word        expBus, expPc, expMar, expIr;
    word        model [16];                   // Expected general registers.
    word        pcModel;
    int         errors;
    int         timeouts;

    datapath UUT (.clk(clk), .rstN(rstN), .ctrl(ctrl), .mdataIn(mdataIn),
                  .busWord(busWord), .pcWord(pcWord), .marAddr(marAddr), .irWord(irWord));

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic reportMismatch(input string name, input word got, input word exp);
        errors++;
        $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    // Outputs are sampled at the edge that closes each strobe cycle.
    busCheck: assert property (@(posedge clk) disable iff (!rstN) chkBus |-> busWord == expBus)
        else reportMismatch("busWord", $sampled(busWord), $sampled(expBus));
    pcCheck: assert property (@(posedge clk) disable iff (!rstN) chkPc |-> pcWord == expPc)
        else reportMismatch("pcWord", $sampled(pcWord), $sampled(expPc));
    marCheck: assert property (@(posedge clk) disable iff (!rstN) chkMar |-> marAddr == expMar)
        else reportMismatch("marAddr", $sampled(marAddr), $sampled(expMar));
    irCheck: assert property (@(posedge clk) disable iff (!rstN) chkIr |-> irWord == expIr)
        else reportMismatch("irWord", $sampled(irWord), $sampled(expIr));

    task automatic finishRun();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    endtask

    // Polls for the next rising edge and gives up if the clock stalls.
    task automatic nextEdge();
        int waited;
        waited = 0;
        while (clk !== 1'b0 && waited < 200)
        begin
            #1;
            waited++;
        end
        while (clk !== 1'b1 && waited < 200)
        begin
            #1;
            waited++;
        end
        if (waited >= 200)
        begin
            $display("Timeout: the clock did not rise within 200 ns at %0t ns", $time);
            timeouts++;
            finishRun();
        end
    endtask

    // One sequencer cycle with the bus value expected during it.
    task automatic step(input ctrlStrobes s, input logic chk, input word exp);
        nextEdge();
        #5;
        ctrl   = s;
        chkBus = chk;
        expBus = exp;
        chkPc  = 1'b0;
        chkMar = 1'b0;
        chkIr  = 1'b0;
    endtask

    function automatic word encode(input opcode code, input regIndex ra, rb, rc);
        instrFields f;
        f = '{op: code, ra: ra, rb: rb, rc: rc, spare: '0};
        return word'(f);
    endfunction

    // Reference ALU with Y as a and the bus as b.
    function automatic dword expectedAlu(input opcode code, input word a, input word b);
        case (code)
            opAdd:   return {32'd0, a + b};
            opSub:   return {32'd0, a - b};
            opAnd:   return {32'd0, a & b};
            opOr:    return {32'd0, a | b};
            opShr:   return {32'd0, a >> b[4:0]};
            opShl:   return {32'd0, a << b[4:0]};
            opMul:   return {32'd0, a} * {32'd0, b};
            opNeg:   return {32'd0, 32'd0 - b};
            opNot:   return {32'd0, ~b};
            default: return {32'd0, b};
        endcase
    endfunction

    task automatic fetchMdr(input word value);
        step(ctrlStrobes'{read: 1'b1, mdrIn: 1'b1, default: 1'b0}, 1'b0, '0);
        mdataIn = value;
    endtask

    task automatic loadIr(input word instr);
        fetchMdr(instr);
        step(ctrlStrobes'{mdrOut: 1'b1, irIn: 1'b1, default: 1'b0}, 1'b1, instr);
        step('0, 1'b1, '0);
        chkIr = 1'b1;
        expIr = instr;
    endtask

    task automatic writeReg(input regIndex idx, input word value);
        loadIr(encode(opAdd, idx, 4'd0, 4'd0));
        fetchMdr(value);
        step(ctrlStrobes'{mdrOut: 1'b1, gra: 1'b1, rIn: 1'b1, default: 1'b0}, 1'b1, value);
        model[idx] = value;
    endtask

    task automatic readReg(input regIndex idx, input word exp);
        loadIr(encode(opAdd, idx, 4'd0, 4'd0));
        step(ctrlStrobes'{gra: 1'b1, rOut: 1'b1, default: 1'b0}, 1'b1, exp);
    endtask

    // With read low the MDR takes the bus and not the memory data input.
    task automatic copyThroughMdr(input regIndex idx);
        loadIr(encode(opAdd, idx, 4'd0, 4'd0));
        step(ctrlStrobes'{gra: 1'b1, rOut: 1'b1, mdrIn: 1'b1, default: 1'b0},
             1'b1, model[idx]);
        mdataIn = ~model[idx];
        step(ctrlStrobes'{mdrOut: 1'b1, default: 1'b0}, 1'b1, model[idx]);
    endtask

    // rb into Y and rc through the ALU into Z, then both halves of Z read back.
    task automatic aluOp(input word instr);
        instrFields f;
        dword       result;
        f      = instrFields'(instr);
        result = expectedAlu(f.op, model[f.rb], model[f.rc]);
        loadIr(instr);
        step(ctrlStrobes'{grb: 1'b1, rOut: 1'b1, yIn: 1'b1, default: 1'b0}, 1'b1, model[f.rb]);
        step(ctrlStrobes'{grc: 1'b1, rOut: 1'b1, zIn: 1'b1, default: 1'b0}, 1'b1, model[f.rc]);
        step(ctrlStrobes'{zLowOut: 1'b1, gra: 1'b1, rIn: 1'b1, default: 1'b0},
             1'b1, result[31:0]);
        step(ctrlStrobes'{zHighOut: 1'b1, default: 1'b0}, 1'b1, result[63:32]);
        model[f.ra] = result[31:0];
    endtask

    task automatic fetch(input word instr);
        step(ctrlStrobes'{pcOut: 1'b1, marIn: 1'b1, zIn: 1'b1, incPc: 1'b1, default: 1'b0},
             1'b1, pcModel);
        step(ctrlStrobes'{zLowOut: 1'b1, pcIn: 1'b1, default: 1'b0}, 1'b1, pcModel + 32'd1);
        chkMar  = 1'b1;
        expMar  = pcModel;
        pcModel = pcModel + 32'd1;
        step('0, 1'b1, '0);
        chkPc = 1'b1;
        expPc = pcModel;
        loadIr(instr);
    endtask

    initial
    begin
        opcode ops [10];
        regIndex ra, rb, rc;
        word val;
        ops = '{opAdd, opSub, opAnd, opOr, opShr, opShl, opMul, opNeg, opNot, opcode'(5'd1)};
        void'($urandom(42));
        {errors, timeouts} = '0;
        {rstN, chkBus, chkPc, chkMar, chkIr} = '0;
        {expBus, expPc, expMar, expIr} = '0;
        ctrl    = '0;
        mdataIn = '0;
        pcModel = '0;
        foreach (model[i])
            model[i] = '0;
        repeat (3)
            nextEdge();
        #5;
        rstN = 1'b1;
        step('0, 1'b1, '0); // Idle bus and cleared registers.
        {chkPc, chkMar, chkIr} = 3'b111;
        repeat (6)
        begin
            ra  = 4'($urandom);
            val = $urandom;
            writeReg(ra, val);
            readReg(ra, model[ra]);
            copyThroughMdr(ra);
        end
        fetch($urandom);
        fetch($urandom);
        writeReg(4'd4, 32'h0000FA92);
        writeReg(4'd5, 32'h000000FF);
        aluOp(32'h20228000);
        readReg(4'd0, 32'h0000F993);
        foreach (ops[i])
        begin
            ra = 4'($urandom);
            rb = 4'($urandom);
            rc = 4'($urandom);
            writeReg(rb, $urandom);
            writeReg(rc, $urandom);
            aluOp(encode(ops[i], ra, rb, rc));
            readReg(ra, model[ra]);
        end
        step('0, 1'b0, '0);
        step('0, 1'b0, '0);
        finishRun();
    end

endmodule

`default_nettype wire

//--- build.f
rtl/dataPkg.sv
rtl/isaPkg.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/memInterface.sv
rtl/aluExecute.sv
rtl/busSelect.sv
rtl/datapath.sv
bench/datapathTb.sv

//--- rtl/aluExecute.sv
`timescale 1ns/1ns
`default_nettype none

module aluExecute
    import dataPkg::*, isaPkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstN,
    input  wire ctrlStrobes ctrl,
    input  wire opcode      op,
    input  wire word        busWord,
    output dword            zData
);

    word  yQ;        // Operand A.
    dword zQ;
    dword aluResult;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            yQ <= '0;
        else if (ctrl.yIn)
            yQ <= busWord;
    end

    // Y is A, the bus is B.
    // Only the multiply reaches the upper half.
    always_comb
    begin
        aluResult = '0;
        if (ctrl.incPc)
        begin
            aluResult[31:0] = busWord + word'(1); // PC increment overrides the opcode.
        end
        else
        begin
            case (op)
                opAdd:   aluResult[31:0] = yQ + busWord;
                opSub:   aluResult[31:0] = yQ - busWord;
                opAnd:   aluResult[31:0] = yQ & busWord;
                opOr:    aluResult[31:0] = yQ | busWord;
                opShr:   aluResult[31:0] = yQ >> busWord[4:0];
                opShl:   aluResult[31:0] = yQ << busWord[4:0];
                opMul:   aluResult       = dword'(yQ) * dword'(busWord);
                opNeg:   aluResult[31:0] = -busWord;
                opNot:   aluResult[31:0] = ~busWord;
                default: aluResult[31:0] = busWord; // Unknown opcode passes B.
            endcase
        end
    end

    // Result register.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            zQ <= '0;
        else if (ctrl.zIn)
            zQ <= aluResult;
    end

    assign zData = zQ;

endmodule

`default_nettype wire

//--- rtl/busSelect.sv
`timescale 1ns/1ns
`default_nettype none

module busSelect
    import dataPkg::*;
(
    input  wire ctrlStrobes ctrl,
    input  wire word        mdrData,
    input  wire dword       zData,
    input  wire word        pcWord,
    input  wire word        regData,
    output word             busWord
);

    // Fixed priority in case the sequencer raises two out strobes.
    always_comb
    begin
        if (ctrl.mdrOut)
            busWord = mdrData;
        else if (ctrl.zLowOut)
            busWord = zData[31:0];
        else if (ctrl.zHighOut)
            busWord = zData[63:32]; // Upper half of a product.
        else if (ctrl.pcOut)
            busWord = pcWord;
        else if (ctrl.rOut)
            busWord = regData;
        else
            busWord = '0;           // Idle bus.
    end

endmodule

`default_nettype wire

//--- rtl/dataPkg.sv
`default_nettype none

package dataPkg;

    typedef logic [31:0] word;     // Bus and register width.
    typedef logic [63:0] dword;    // Z register, wide enough for a product.
    typedef logic [3:0]  regIndex; // General register number, R0 to R15.

    // Level strobes from the sequencer.
    // A strobe that is high at a rising edge loads its register.
    typedef struct packed {
        logic gra;      // Register named by the ra field.
        logic grb;      // Register named by the rb field.
        logic grc;      // Register named by the rc field.
        logic rIn;      // Write the selected general register.
        logic rOut;     // Selected general register drives the bus.
        logic pcIn;
        logic pcOut;
        logic marIn;
        logic mdrIn;
        logic mdrOut;
        logic read;     // MDR takes the memory data input.
        logic yIn;
        logic zIn;
        logic zLowOut;
        logic zHighOut;
        logic irIn;
        logic incPc;    // Z gets bus plus one.
    } ctrlStrobes;

endpackage

`default_nettype wire

//--- rtl/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath
    import dataPkg::*, isaPkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstN,
    input  wire ctrlStrobes ctrl,
    input  wire word        mdataIn,
    output word             busWord,
    output word             pcWord,
    output word             marAddr,
    output word             irWord
);

    opcode   op;
    regIndex regSel;
    word     regData;
    word     mdrData;
    dword    zData;
    word     pcQ;

    // Program counter, advanced through Z with incPc.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            pcQ <= '0;
        else if (ctrl.pcIn)
            pcQ <= busWord;
    end

    assign pcWord = pcQ;

    instrDecode decode (
        .clk     (clk),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .busWord (busWord),
        .irWord  (irWord),
        .op      (op),
        .regSel  (regSel)
    );

    regFile regs (
        .clk     (clk),
        .rstN    (rstN),
        .regSel  (regSel),
        .rIn     (ctrl.rIn),
        .busWord (busWord),
        .regData (regData)
    );

    memInterface mem (
        .clk     (clk),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .busWord (busWord),
        .mdataIn (mdataIn),
        .marAddr (marAddr),
        .mdrData (mdrData)
    );

    aluExecute execute (
        .clk     (clk),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .op      (op),
        .busWord (busWord),
        .zData   (zData)
    );

    busSelect result (
        .ctrl    (ctrl),
        .mdrData (mdrData),
        .zData   (zData),
        .pcWord  (pcQ),
        .regData (regData),
        .busWord (busWord)
    );

endmodule

`default_nettype wire

//--- rtl/instrDecode.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecode
    import dataPkg::*, isaPkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstN,
    input  wire ctrlStrobes ctrl,
    input  wire word        busWord,
    output word             irWord,
    output opcode           op,
    output regIndex         regSel
);

    word        irQ;
    instrFields irFields;

    // Instruction register.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            irQ <= '0;
        else if (ctrl.irIn)
            irQ <= busWord;
    end

    assign irFields = instrFields'(irQ); // Split into fields.
    assign irWord   = irQ;
    assign op       = irFields.op;

    // Register select, gra wins over grb, grb over grc.
    always_comb
    begin
        if (ctrl.gra)
            regSel = irFields.ra;
        else if (ctrl.grb)
            regSel = irFields.rb;
        else if (ctrl.grc)
            regSel = irFields.rc;
        else
            regSel = '0;
    end

endmodule

`default_nettype wire

//--- rtl/isaPkg.sv
`default_nettype none

package isaPkg;

    import dataPkg::*;

    // ALU opcodes.
    // The gaps belong to instructions this datapath does not execute.
    typedef enum logic [4:0] {
        opAdd = 5'd3,
        opSub = 5'd4,
        opAnd = 5'd5,
        opOr  = 5'd6,
        opShr = 5'd7,
        opShl = 5'd9,
        opMul = 5'd15,
        opNeg = 5'd17,
        opNot = 5'd18
    } opcode;

    // Instruction word layout, most significant field first.
    typedef struct packed {
        opcode         op;    // Bits 31..27.
        regIndex       ra;    // Bits 26..23, destination.
        regIndex       rb;    // Bits 22..19, first source.
        regIndex       rc;    // Bits 18..15, second source.
        logic [14:0]   spare; // Not decoded here.
    } instrFields;

    // 0x20228000 decodes as sub R0, R4, R5.

endpackage

`default_nettype wire

//--- rtl/memInterface.sv
`timescale 1ns/1ns
`default_nettype none

module memInterface
    import dataPkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstN,
    input  wire ctrlStrobes ctrl,
    input  wire word        busWord,
    input  wire word        mdataIn,
    output word             marAddr,
    output word             mdrData
);

    word marQ;
    word mdrQ;
    word mdrNext;

    assign mdrNext = ctrl.read ? mdataIn : busWord; // Memory side or bus side.

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            marQ <= '0;
            mdrQ <= '0;
        end
        else
        begin
            if (ctrl.marIn)
                marQ <= busWord;
            if (ctrl.mdrIn)
                mdrQ <= mdrNext;
        end
    end

    assign marAddr = marQ;
    assign mdrData = mdrQ;

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile
    import dataPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire regIndex regSel,
    input  wire logic    rIn,
    input  wire word     busWord,
    output word          regData
);

    word regs [16]; // R0 to R15.

    // One write port, addressed by the decoded IR field.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end
        else if (rIn)
        begin
            regs[regSel] <= busWord;
        end
    end

    // Combinational read of the same register.
    assign regData = regs[regSel];

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        -f build.f --top-module datapathTb -o simv; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/simv > sim.log 2>&1; then
    cat sim.log
    echo "Simulation did not run to completion"
    exit 1
fi
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
